/* source/sys_params_pkg.sv */
// System parameters for the physical register file
// Sizes, port counts and the clear sweep length
`default_nettype none

package sys_params_pkg;

    ////////////////////////////////////////
    // Register file geometry
    ////////////////////////////////////////

    // Physical registers in the R10K-style file
    localparam int PHYS_REG_SZ = 64;

    // Register index width
    localparam int IDX_W = $clog2(PHYS_REG_SZ);

    // Data word width
    localparam int DATA_W = 32;

    // Hard-wired zero register
    localparam int ZERO_REG = 0;

    ////////////////////////////////////////
    // Port counts
    ////////////////////////////////////////

    // Writeback ports, also the clear width per cycle
    localparam int N = 2;

    // Functional units, two read ports each
    localparam int NUM_FU = 3;

    // Cycles spent sweeping zeros after reset
    localparam int CLEAR_STEPS = PHYS_REG_SZ / N;

endpackage

`default_nettype wire

/* source/regfile_types_pkg.sv */
// Data types for the register file ports
// Register index, data word and writeback request
`default_nettype none

package regfile_types_pkg;

    import sys_params_pkg::*;

    ////////////////////////////////////////
    // Scalar types
    ////////////////////////////////////////

    // Physical register index
    typedef logic [IDX_W-1:0] phys_reg_idx_t;

    // One data word
    typedef logic [DATA_W-1:0] data_t;

    ////////////////////////////////////////
    // Writeback request
    ////////////////////////////////////////

    // One writeback port, valid is a plain strobe
    typedef struct packed {
        logic          valid;
        phys_reg_idx_t idx;
        data_t         data;
    } write_req_t;

    // Port bundles, index 0 is the lowest priority port
    typedef write_req_t    [N-1:0]      write_reqs_t;
    typedef phys_reg_idx_t [NUM_FU-1:0] read_idxs_t;
    typedef data_t         [NUM_FU-1:0] read_datas_t;

endpackage

`default_nettype wire

/* source/mem_dp.sv */
// Multi-ported storage array
// Combinational reads, clocked writes, no reset on the contents
// Higher numbered write port wins an address conflict
`timescale 1ns/1ps
`default_nettype none

module mem_dp
    import regfile_types_pkg::*;
#(
    parameter int WIDTH       = $bits(data_t),
    parameter int DEPTH       = 1 << $bits(phys_reg_idx_t),
    parameter int READ_PORTS  = 2,
    parameter int WRITE_PORTS = 1
) (
    input  wire logic                                   clock,

    // Read side
    input  wire logic          [READ_PORTS-1:0]         re,
    input  wire phys_reg_idx_t [READ_PORTS-1:0]         raddr,
    output logic               [READ_PORTS-1:0][WIDTH-1:0] rdata,

    // Write side
    input  wire logic          [WRITE_PORTS-1:0]        we,
    input  wire phys_reg_idx_t [WRITE_PORTS-1:0]        waddr,
    input  wire logic          [WRITE_PORTS-1:0][WIDTH-1:0] wdata
);

    ////////////////////////////////////////
    // Storage
    ////////////////////////////////////////

    // Contents are undefined until written
    logic [WIDTH-1:0] mem [DEPTH];

    ////////////////////////////////////////
    // Write ports
    ////////////////////////////////////////

    // Applied in port order
    // A later port overrides an earlier one on the same address
    always_ff @(posedge clock) begin
        for (int i = 0; i < WRITE_PORTS; i++) begin
            if (we[i]) begin
                mem[waddr[i]] <= wdata[i];
            end
        end
    end

    ////////////////////////////////////////
    // Read ports
    ////////////////////////////////////////

    // No internal bypass
    // Same-cycle write shows up on the next cycle
    always_comb begin
        for (int i = 0; i < READ_PORTS; i++) begin
            if (re[i]) begin
                rdata[i] = mem[raddr[i]];
            end else begin
                // Disabled port reads as zero
                rdata[i] = '0;
            end
        end
    end

endmodule

`default_nettype wire

/* source/regfile.sv */
// Physical register file
// Wraps the storage array and hard-wires register 0 to zero
// One read pair per functional unit, N writeback ports
`timescale 1ns/1ps
`default_nettype none

module regfile
    import sys_params_pkg::*;
    import regfile_types_pkg::*;
(
    input  wire logic        clock,

    // Writeback requests, already gated by the clear sequencer
    input  wire write_reqs_t wreqs,

    // Operand reads per functional unit
    input  wire read_idxs_t  read_idx_1,
    input  wire read_idxs_t  read_idx_2,
    output read_datas_t      read_out_1,
    output read_datas_t      read_out_2
);

    localparam int RP = 2 * NUM_FU;

    // Both read banks flattened, bank 2 in the upper half
    phys_reg_idx_t [RP-1:0] raddr;
    data_t         [RP-1:0] rdata;
    logic          [RP-1:0] re;

    // Write side unpacked from the request structs
    logic          [N-1:0]  we;
    phys_reg_idx_t [N-1:0]  waddr;
    data_t         [N-1:0]  wdata;

    ////////////////////////////////////////
    // Storage
    ////////////////////////////////////////

    mem_dp #(
        .WIDTH       (DATA_W),
        .DEPTH       (PHYS_REG_SZ),
        .READ_PORTS  (RP),
        .WRITE_PORTS (N)
    ) i_mem_dp (
        .clock (clock),
        .re    (re),
        .raddr (raddr),
        .rdata (rdata),
        .we    (we),
        .waddr (waddr),
        .wdata (wdata)
    );

    ////////////////////////////////////////
    // Read masking
    ////////////////////////////////////////

    assign raddr = {read_idx_2, read_idx_1};

    // Register 0 never touches the array
    // A disabled port comes back from the array as zero
    always_comb begin
        for (int i = 0; i < RP; i++) begin
            re[i] = (raddr[i] != phys_reg_idx_t'(ZERO_REG));
        end
    end

    assign {read_out_2, read_out_1} = rdata;

    ////////////////////////////////////////
    // Write masking
    ////////////////////////////////////////

    // Writes to register 0 are dropped here
    always_comb begin
        for (int i = 0; i < N; i++) begin
            we[i]    = wreqs[i].valid && (wreqs[i].idx != phys_reg_idx_t'(ZERO_REG));
            waddr[i] = wreqs[i].idx;
            wdata[i] = wreqs[i].data;
        end
    end

endmodule

`default_nettype wire

/* source/clear_index_counter.sv */
// Base index counter for the post-reset clear sweep
// Steps by N per enabled cycle and flags the final step
`timescale 1ns/1ps
`default_nettype none

module clear_index_counter
    import sys_params_pkg::*;
    import regfile_types_pkg::*;
(
    input  wire logic    clock,
    input  wire logic    rst_n,
    input  wire logic    en,
    output phys_reg_idx_t base,
    output logic         last
);

    // Last group of N registers starts here
    localparam phys_reg_idx_t LAST_BASE = phys_reg_idx_t'(PHYS_REG_SZ - N);

    assign last = (base == LAST_BASE);

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            base <= '0;
        end else if (en) begin
            // Wrap back to zero after the last step
            if (last) begin
                base <= '0;
            end else begin
                base <= base + phys_reg_idx_t'(N);
            end
        end
    end

endmodule

`default_nettype wire

/* source/regfile_clear_fsm.sv */
// Clear sequencer for the register file
// Sweeps zeros into every register after reset, then raises ready
// and passes writeback requests through
`timescale 1ns/1ps
`default_nettype none

module regfile_clear_fsm
    import sys_params_pkg::*;
    import regfile_types_pkg::*;
(
    input  wire logic          clock,
    input  wire logic          rst_n,
    input  wire write_reqs_t   wb_reqs,
    input  wire phys_reg_idx_t clear_base,
    input  wire logic          clear_last,
    output logic               clear_en,
    output write_reqs_t        rf_wreqs,
    output logic               ready
);

    typedef enum logic [1:0] {
        RESET,
        CLEAR,
        READY
    } state_e;

    state_e state;
    state_e state_next;

    ////////////////////////////////////////
    // State register
    ////////////////////////////////////////

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            state <= RESET;
        end else begin
            state <= state_next;
        end
    end

    // RESET lasts one edge, CLEAR lasts CLEAR_STEPS edges
    always_comb begin
        case (state)
            RESET:   state_next = CLEAR;
            CLEAR:   state_next = clear_last ? READY : CLEAR;
            READY:   state_next = READY;
            default: state_next = RESET;
        endcase
    end

    assign clear_en = (state == CLEAR);
    assign ready    = (state == READY);

    ////////////////////////////////////////
    // Write port mux
    ////////////////////////////////////////

    always_comb begin
        for (int k = 0; k < N; k++) begin
            if (clear_en) begin
                // Port k zeroes register base + k
                rf_wreqs[k].valid = 1'b1;
                rf_wreqs[k].idx   = clear_base + phys_reg_idx_t'(k);
                rf_wreqs[k].data  = '0;
            end else begin
                // Writeback dropped until ready
                rf_wreqs[k]       = wb_reqs[k];
                rf_wreqs[k].valid = wb_reqs[k].valid & ready;
            end
        end
    end

endmodule

`default_nettype wire

/* source/regfile_top.sv */
// Register file top level
// Clear sequencer, sweep counter and register file
`timescale 1ns/1ps
`default_nettype none

module regfile_top
    import regfile_types_pkg::*;
(
    input  wire logic        clock,
    input  wire logic        rst_n,

    // From writeback
    input  wire write_reqs_t wb_reqs,

    // From issue
    input  wire read_idxs_t  read_idx_1,
    input  wire read_idxs_t  read_idx_2,
    output read_datas_t      read_out_1,
    output read_datas_t      read_out_2,

    // High once every register holds zero
    output logic             ready
);

    logic          clear_en;
    logic          clear_last;
    phys_reg_idx_t clear_base;
    write_reqs_t   rf_wreqs;

    ////////////////////////////////////////
    // Clear sweep
    ////////////////////////////////////////

    regfile_clear_fsm i_regfile_clear_fsm (
        .clock      (clock),
        .rst_n      (rst_n),
        .wb_reqs    (wb_reqs),
        .clear_base (clear_base),
        .clear_last (clear_last),
        .clear_en   (clear_en),
        .rf_wreqs   (rf_wreqs),
        .ready      (ready)
    );

    clear_index_counter i_clear_index_counter (
        .clock (clock),
        .rst_n (rst_n),
        .en    (clear_en),
        .base  (clear_base),
        .last  (clear_last)
    );

    ////////////////////////////////////////
    // Storage
    ////////////////////////////////////////

    regfile i_regfile (
        .clock      (clock),
        .wreqs      (rf_wreqs),
        .read_idx_1 (read_idx_1),
        .read_idx_2 (read_idx_2),
        .read_out_1 (read_out_1),
        .read_out_2 (read_out_2)
    );

endmodule

`default_nettype wire

/* verif/regfile_checker.sv */
// Concurrent assertions on the register file top level
// Ready stability, zero register reads and write gating before ready
`timescale 1ns/1ps
`default_nettype none

module regfile_checker
    import sys_params_pkg::*;
    import regfile_types_pkg::*;
(
    input  wire logic        clock,
    input  wire logic        rst_n,
    input  wire logic        ready,
    input  wire logic        clear_en,
    input  wire write_reqs_t rf_wreqs,
    input  wire read_idxs_t  read_idx_1,
    input  wire read_idxs_t  read_idx_2,
    input  wire read_datas_t read_out_1,
    input  wire read_datas_t read_out_2
);

    ////////////////////////////////////////
    // Ready level
    ////////////////////////////////////////

    // Once up, ready holds until the next reset
    ready_stays_high: assert property (@(posedge clock) disable iff (!rst_n)
        ready |=> ready)
        else $error("ready fell while out of reset");

    ////////////////////////////////////////
    // Zero register reads
    ////////////////////////////////////////

    for (genvar f = 0; f < NUM_FU; f++) begin : g_zero_reads
        zero_read_1: assert property (@(posedge clock) disable iff (!rst_n)
            (read_idx_1[f] == phys_reg_idx_t'(ZERO_REG)) |-> (read_out_1[f] == '0))
            else $error("read_out_1 port returned nonzero for the zero register");
        zero_read_2: assert property (@(posedge clock) disable iff (!rst_n)
            (read_idx_2[f] == phys_reg_idx_t'(ZERO_REG)) |-> (read_out_2[f] == '0))
            else $error("read_out_2 port returned nonzero for the zero register");
    end

    ////////////////////////////////////////
    // Write gating
    ////////////////////////////////////////

    // Before ready only the zero sweep may write
    for (genvar k = 0; k < N; k++) begin : g_write_gate
        no_wb_before_ready: assert property (@(posedge clock) disable iff (!rst_n)
            !ready |-> (!rf_wreqs[k].valid || (clear_en && rf_wreqs[k].data == '0)))
            else $error("writeback request reached the register file before ready");
    end

endmodule

`default_nettype wire

/* verif/regfile_tb.sv */
// Random testbench for the register file top level
// Reference model of the physical registers, clear sweep timing
// and directed corner cases for the zero register and port priority
`timescale 1ns/1ps
`default_nettype none

bind regfile_top regfile_checker i_regfile_checker (
    .clock      (clock),
    .rst_n      (rst_n),
    .ready      (ready),
    .clear_en   (clear_en),
    .rf_wreqs   (rf_wreqs),
    .read_idx_1 (read_idx_1),
    .read_idx_2 (read_idx_2),
    .read_out_1 (read_out_1),
    .read_out_2 (read_out_2)
);

module regfile_tb
    import sys_params_pkg::*;
    import regfile_types_pkg::*;
;

    // Reset, clear sweep, index sweep, 1000 random cycles and directed cases
    localparam int TIMEOUT_CYCLES = 2000;
    localparam int RANDOM_CYCLES  = 1000;

    logic        clock;
    logic        rst_n;
    write_reqs_t wb_reqs;
    read_idxs_t  read_idx_1;
    read_idxs_t  read_idx_2;
    read_datas_t read_out_1;
    read_datas_t read_out_2;
    logic        ready;

    // Expected contents of every physical register
    data_t model [PHYS_REG_SZ];
    int    seed;
    int    cycle_count;

    // Writes driven in this cycle land in the model
    logic  writes_accepted;

    regfile_top i_regfile_top (
        .clock      (clock),
        .rst_n      (rst_n),
        .wb_reqs    (wb_reqs),
        .read_idx_1 (read_idx_1),
        .read_idx_2 (read_idx_2),
        .read_out_1 (read_out_1),
        .read_out_2 (read_out_2),
        .ready      (ready)
    );

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    // Watchdog
    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clock);
            cycle_count++;
        end
        $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Test failures found");
        $fatal(1);
    end

    ////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////

    task automatic check_value(input string name, input logic [DATA_W-1:0] expected,
                               input logic [DATA_W-1:0] actual);
        if (actual !== expected) begin
            $display("error: time %0t signal %s expected %h actual %h",
                     $time, name, expected, actual);
            $display("Test failures found");
            $fatal(1);
        end
    endtask

    function automatic write_reqs_t random_reqs();
        write_reqs_t reqs;
        logic [31:0] r;
        for (int k = 0; k < N; k++) begin
            r             = $random(seed);
            reqs[k].valid = r[0];
            reqs[k].idx   = r[IDX_W:1];
            reqs[k].data  = $random(seed);
        end
        return reqs;
    endfunction

    function automatic read_idxs_t random_idxs();
        read_idxs_t  idxs;
        logic [31:0] r;
        for (int f = 0; f < NUM_FU; f++) begin
            r       = $random(seed);
            idxs[f] = r[IDX_W-1:0];
        end
        return idxs;
    endfunction

    function automatic read_idxs_t same_idxs(input phys_reg_idx_t idx);
        read_idxs_t idxs;
        for (int f = 0; f < NUM_FU; f++) begin
            idxs[f] = idx;
        end
        return idxs;
    endfunction

    // Register 0 reads zero, the rest come from the model
    function automatic data_t expected_word(input phys_reg_idx_t idx);
        if (idx == phys_reg_idx_t'(ZERO_REG)) begin
            return '0;
        end
        return model[idx];
    endfunction

    task automatic check_reads();
        for (int f = 0; f < NUM_FU; f++) begin
            check_value($sformatf("read_out_1[%0d]", f), expected_word(read_idx_1[f]),
                        read_out_1[f]);
            check_value($sformatf("read_out_2[%0d]", f), expected_word(read_idx_2[f]),
                        read_out_2[f]);
        end
    endtask

    // Port order, so the higher port wins a shared index
    task automatic apply_writes();
        if (writes_accepted) begin
            for (int k = 0; k < N; k++) begin
                if (wb_reqs[k].valid && wb_reqs[k].idx != phys_reg_idx_t'(ZERO_REG)) begin
                    model[wb_reqs[k].idx] = wb_reqs[k].data;
                end
            end
        end
    endtask

    // Drive on the rising edge, check at the falling edge, then commit the writes
    task automatic step_cycle(input write_reqs_t reqs, input read_idxs_t r1,
                              input read_idxs_t r2, input logic check_en);
        @(posedge clock);
        wb_reqs    <= reqs;
        read_idx_1 <= r1;
        read_idx_2 <= r2;
        @(negedge clock);
        if (check_en) begin
            check_reads();
        end
        apply_writes();
    endtask

    ////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////

    initial begin
        write_reqs_t reqs;
        read_idxs_t  r1;
        read_idxs_t  r2;
        data_t       old_word;
        data_t       new_word;

        seed            = 62072;
        rst_n           = 1'b0;
        wb_reqs         = '0;
        read_idx_1      = '0;
        read_idx_2      = '0;
        writes_accepted = 1'b0;
        for (int i = 0; i < PHYS_REG_SZ; i++) begin
            model[i] = '0;
        end

        repeat (2) @(posedge clock);

        // Writeback arrives while the FSM still sits in RESET
        reqs = random_reqs();
        for (int k = 0; k < N; k++) begin
            reqs[k].valid = 1'b1;
        end
        rst_n   <= 1'b1;
        wb_reqs <= reqs;

        // Clear sweep with random writes that must be dropped
        // Ready rises CLEAR_STEPS+1 edges after release
        for (int i = 1; i <= CLEAR_STEPS + 1; i++) begin
            writes_accepted = (i == CLEAR_STEPS + 1);
            step_cycle(random_reqs(), random_idxs(), random_idxs(), 1'b0);
            check_value("ready", DATA_W'(writes_accepted), DATA_W'(ready));
        end

        // Every register reads zero on every port
        for (int i = 0; i < PHYS_REG_SZ; i++) begin
            for (int f = 0; f < NUM_FU; f++) begin
                r1[f] = phys_reg_idx_t'((i + f) % PHYS_REG_SZ);
                r2[f] = phys_reg_idx_t'((i + NUM_FU + f) % PHYS_REG_SZ);
            end
            step_cycle('0, r1, r2, 1'b1);
        end

        // Random traffic against the model
        for (int i = 0; i < RANDOM_CYCLES; i++) begin
            step_cycle(random_reqs(), random_idxs(), random_idxs(), 1'b1);
        end

        // Zero register ignores writes
        reqs = '0;
        for (int k = 0; k < N; k++) begin
            reqs[k].valid = 1'b1;
            reqs[k].idx   = phys_reg_idx_t'(ZERO_REG);
            reqs[k].data  = 32'hdead_beef;
        end
        step_cycle(reqs, random_idxs(), random_idxs(), 1'b1);
        step_cycle('0, same_idxs(phys_reg_idx_t'(ZERO_REG)),
                   same_idxs(phys_reg_idx_t'(ZERO_REG)), 1'b1);
        check_value("read_out_1[0]", '0, read_out_1[0]);
        check_value("read_out_2[0]", '0, read_out_2[0]);

        // Both ports on one index
        reqs            = '0;
        reqs[0].valid   = 1'b1;
        reqs[0].idx     = phys_reg_idx_t'(10);
        reqs[0].data    = 32'h1111_aaaa;
        reqs[N-1].valid = 1'b1;
        reqs[N-1].idx   = phys_reg_idx_t'(10);
        reqs[N-1].data  = 32'h2222_bbbb;
        step_cycle(reqs, random_idxs(), random_idxs(), 1'b1);
        step_cycle('0, same_idxs(phys_reg_idx_t'(10)), same_idxs(phys_reg_idx_t'(10)), 1'b1);
        check_value("read_out_1[0]", 32'h2222_bbbb, read_out_1[0]);

        // Read during a write sees the old word, then the new one
        old_word      = model[20];
        new_word      = ~old_word;
        reqs          = '0;
        reqs[0].valid = 1'b1;
        reqs[0].idx   = phys_reg_idx_t'(20);
        reqs[0].data  = new_word;
        step_cycle(reqs, same_idxs(phys_reg_idx_t'(20)), same_idxs(phys_reg_idx_t'(20)), 1'b1);
        check_value("read_out_1[0]", old_word, read_out_1[0]);
        step_cycle('0, same_idxs(phys_reg_idx_t'(20)), same_idxs(phys_reg_idx_t'(20)), 1'b1);
        check_value("read_out_1[0]", new_word, read_out_1[0]);

        $display("All tests passed!");
        $finish;
    end

endmodule

`default_nettype wire

/* tb.f */
source/sys_params_pkg.sv
source/regfile_types_pkg.sv
source/mem_dp.sv
source/regfile.sv
source/clear_index_counter.sv
source/regfile_clear_fsm.sv
source/regfile_top.sv
verif/regfile_checker.sv
verif/regfile_tb.sv

/* run.sh */
#!/bin/sh
# Compile and run the register file testbench with Verilator
rm -rf obj_dir build.log sim.log
verilator --binary --timing --assert --top-module regfile_tb -f tb.f > build.log 2>&1 \
    || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/Vregfile_tb > sim.log 2>&1 || echo "simulator exited with an error" >> sim.log
cat sim.log
grep -q "Test failures found" sim.log && { echo "simulation failed"; exit 1; }
grep -q "All tests passed!" sim.log || { echo "simulation did not complete"; exit 1; }
exit 0
